// File: source/sa_acc_config.svh
`ifndef SA_ACC_CONFIG_SVH
`define SA_ACC_CONFIG_SVH

// Array geometry
`define SA_PE_SIZE       4

// Operand and accumulator widths
`define SA_DATA_WIDTH    8     // Activation, weight, output
`define SA_PSUM_WIDTH    32

// Vectors per pass, also entries per column FIFO
`define SA_FIFO_DEPTH    4

// Output slice ends at bit SA_SLICING_IDX-1
`define SA_SLICING_IDX   16

// Drain-out time of the skewed array, 2 x PE_SIZE
`define SA_FLUSH_CYCLES  8

`endif

// File: source/sa_acc_pkg.sv
`default_nettype none

`include "sa_acc_config.svh"

package sa_acc_pkg;

    // Scalar widths
    typedef logic [`SA_DATA_WIDTH-1:0]       data_t;    // Activation or weight
    typedef logic [`SA_PSUM_WIDTH-1:0]       psum_t;    // Partial sum
    typedef logic [$clog2(`SA_PE_SIZE)-1:0]  idx_t;     // Row or column select

    // Row bundles, column 0 sits in the top slot
    typedef data_t [0:`SA_PE_SIZE-1] data_row_t;
    typedef psum_t [0:`SA_PE_SIZE-1] psum_row_t;
    typedef logic  [`SA_PE_SIZE-1:0] col_mask_t;        // One bit per column

    // One weight row write
    typedef struct packed {
        logic      we;
        idx_t      row;
        data_row_t data;
    } wgt_wr_t;

    // Pass command, drain sampled with start
    typedef struct packed {
        logic start;
        logic drain;
    } pass_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FEED,    // Taking activation vectors
        ST_FLUSH,   // Waiting for the last column
        ST_DRAIN    // Reading FIFOs out
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/mac_pe.sv
`timescale 1ns/1ps
`default_nettype none

module mac_pe (
    input  wire                      clk,
    input  wire                      arst_n_i,
    input  wire                      w_load_i,    // Weight write strobe
    input  wire  sa_acc_pkg::data_t  w_i,
    input  wire  sa_acc_pkg::data_t  a_i,         // From the left neighbour
    input  wire                      a_valid_i,
    input  wire  sa_acc_pkg::psum_t  psum_i,      // From the PE above
    output sa_acc_pkg::data_t        a_o,         // To the right neighbour
    output logic                     a_valid_o,
    output sa_acc_pkg::psum_t        psum_o       // To the PE below
);
    import sa_acc_pkg::*;

    data_t w_q;     // Stationary weight

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            w_q <= '0;
        end else if (w_load_i) begin
            w_q <= w_i;
        end
    end

    // Activation hop and MAC stage share one register slot
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a_o       <= '0;
            a_valid_o <= 1'b0;
            psum_o    <= '0;
        end else begin
            a_valid_o <= a_valid_i;     // Valid always moves
            if (a_valid_i) begin
                a_o    <= a_i;
                // Unsigned product, wraps at 32 bits
                psum_o <= psum_i + psum_t'(a_i) * psum_t'(w_q);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_acc_config.svh"

module systolic_array (
    input  wire                          clk,
    input  wire                          arst_n_i,
    input  wire  sa_acc_pkg::wgt_wr_t    wgt_wr_i,
    input  wire                          act_valid_i,    // Already gated to feed phase
    input  wire  sa_acc_pkg::data_row_t  act_i,
    output sa_acc_pkg::col_mask_t        psum_valid_o,   // Column c, N+c cycles after feed
    output sa_acc_pkg::psum_row_t        psum_row_o
);
    import sa_acc_pkg::*;

    localparam int N = `SA_PE_SIZE;

    // Horizontal links, column N is the open right edge
    data_t a_link [0:N-1][0:N];
    logic  v_link [0:N-1][0:N];

    // Vertical links, row 0 is tied to zero
    psum_t p_link [0:N][0:N-1];

    // Input skew, row r delayed by r stages
    for (genvar r = 0; r < N; r++) begin : g_skew
        if (r == 0) begin : g_direct
            assign a_link[0][0] = act_i[0];
            assign v_link[0][0] = act_valid_i;
        end else begin : g_delay
            data_t        sk_d [0:r-1];
            logic [r-1:0] sk_v;

            always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                    for (int k = 0; k < r; k++) begin
                        sk_d[k] <= '0;
                    end
                    sk_v <= '0;
                end else begin
                    sk_d[0] <= act_i[r];
                    sk_v[0] <= act_valid_i;
                    for (int k = 1; k < r; k++) begin   // Shift along
                        sk_d[k] <= sk_d[k-1];
                        sk_v[k] <= sk_v[k-1];
                    end
                end
            end

            assign a_link[r][0] = sk_d[r-1];
            assign v_link[r][0] = sk_v[r-1];
        end
    end

    // PE grid
    for (genvar r = 0; r < N; r++) begin : g_row
        logic w_load;   // Row select decode

        assign w_load = wgt_wr_i.we && (wgt_wr_i.row == idx_t'(r));

        for (genvar c = 0; c < N; c++) begin : g_col
            mac_pe u_pe (
                .clk       (clk),
                .arst_n_i  (arst_n_i),
                .w_load_i  (w_load),
                .w_i       (wgt_wr_i.data[c]),
                .a_i       (a_link[r][c]),
                .a_valid_i (v_link[r][c]),
                .psum_i    (p_link[r][c]),
                .a_o       (a_link[r][c+1]),
                .a_valid_o (v_link[r][c+1]),
                .psum_o    (p_link[r+1][c])
            );
        end
    end

    // Column edges
    for (genvar c = 0; c < N; c++) begin : g_edge
        assign p_link[0][c]    = '0;
        assign psum_row_o[c]   = p_link[N][c];
        // Bottom PE forwards its valid in step with its psum register
        assign psum_valid_o[c] = v_link[N-1][c+1];
    end

endmodule

`default_nettype wire

// File: source/acc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module acc_fifo #(
    parameter int DEPTH = 4
) (
    input  wire                      clk,
    input  wire                      arst_n_i,
    input  wire                      wr_en_i,
    input  wire                      rd_en_i,
    input  wire  sa_acc_pkg::psum_t  wdata_i,
    output sa_acc_pkg::psum_t        rdata_o,     // Head, no read needed
    output logic                     full_o,
    output logic                     empty_o
);
    import sa_acc_pkg::*;

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    psum_t         mem [0:DEPTH-1];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          do_wr;
    logic          do_rd;

    // Wrap at DEPTH, also for non power of two
    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full_o  = (count_q == CW'(DEPTH));
    assign empty_o = (count_q == '0);

    assign do_rd = rd_en_i && !empty_o;
    assign do_wr = wr_en_i && (!full_o || do_rd);   // Full plus read keeps it full

    assign rdata_o = mem[rd_ptr_q];   // Fall-through head

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wdata_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_rd) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // Idle or both
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/psum_acc.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_acc_config.svh"

module psum_acc (
    input  wire                          clk,
    input  wire                          arst_n_i,
    input  wire  sa_acc_pkg::col_mask_t  psum_valid_i,   // Per-column write strobe
    input  wire  sa_acc_pkg::psum_row_t  psum_row_i,
    input  wire                          rd_en_i,        // Drain read, all columns
    output sa_acc_pkg::data_row_t        out_row_o
);
    import sa_acc_pkg::*;

    localparam int N = `SA_PE_SIZE;

    psum_t     head  [0:N-1];   // FIFO heads
    psum_t     wdata [0:N-1];   // Sum to store
    col_mask_t full;            // Doubles as accumulate enable
    col_mask_t rd;

    for (genvar c = 0; c < N; c++) begin : g_col
        // Zero feedback until the first pass has filled the FIFO
        assign wdata[c] = psum_row_i[c] + (full[c] ? head[c] : '0);

        // Pop the consumed head while accumulating, or drain
        assign rd[c] = (psum_valid_i[c] & full[c]) | rd_en_i;

        acc_fifo #(
            .DEPTH (`SA_FIFO_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .wr_en_i  (psum_valid_i[c]),
            .rd_en_i  (rd[c]),
            .wdata_i  (wdata[c]),
            .rdata_o  (head[c]),
            .full_o   (full[c]),
            .empty_o  ()
        );

        // Quantized output slice
        assign out_row_o[c] = head[c][`SA_SLICING_IDX-1 -: `SA_DATA_WIDTH];
    end

endmodule

`default_nettype wire

// File: source/tile_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_acc_config.svh"

module tile_ctrl (
    input  wire                          clk,
    input  wire                          arst_n_i,
    input  wire  sa_acc_pkg::pass_cmd_t  cmd_i,
    input  wire                          act_valid_i,
    output logic                         cnt_load_o,
    output logic [3:0]                   cnt_val_o,
    output logic                         cnt_en_o,
    input  wire                          cnt_zero_i,    // Phase done
    output logic                         feed_o,        // Gated activation strobe
    output logic                         rd_en_o,
    output logic                         busy_o,
    output logic                         done_o
);
    import sa_acc_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        drain_q;   // Drain flag of the running pass

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            drain_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE && cmd_i.start) begin
                drain_q <= cmd_i.drain;
            end
        end
    end

    // Next state and counter reloads
    always_comb begin
        state_d    = state_q;
        cnt_load_o = 1'b0;
        cnt_val_o  = '0;
        done_o     = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (cmd_i.start) begin
                    state_d    = ST_FEED;
                    cnt_load_o = 1'b1;
                    cnt_val_o  = 4'(`SA_FIFO_DEPTH);    // Vectors to take
                end
            end
            ST_FEED: begin
                if (cnt_zero_i) begin
                    state_d    = ST_FLUSH;
                    cnt_load_o = 1'b1;
                    cnt_val_o  = 4'(`SA_FLUSH_CYCLES);
                end
            end
            ST_FLUSH: begin
                if (cnt_zero_i) begin
                    if (drain_q) begin
                        state_d    = ST_DRAIN;
                        cnt_load_o = 1'b1;
                        cnt_val_o  = 4'(`SA_FIFO_DEPTH);    // Rows to read
                    end else begin
                        state_d = ST_IDLE;
                        done_o  = 1'b1;     // Sums stay in the FIFOs
                    end
                end
            end
            ST_DRAIN: begin
                if (cnt_zero_i) begin
                    state_d = ST_IDLE;
                    done_o  = 1'b1;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    assign feed_o   = act_valid_i && (state_q == ST_FEED);
    // Feed counts vectors, other phases count cycles
    assign cnt_en_o = (state_q == ST_FEED) ? act_valid_i : (state_q != ST_IDLE);
    assign rd_en_o  = (state_q == ST_DRAIN);
    assign busy_o   = (state_q != ST_IDLE);

endmodule

`default_nettype wire

// File: source/phase_counter.sv
`timescale 1ns/1ps
`default_nettype none

module phase_counter (
    input  wire        clk,
    input  wire        arst_n_i,
    input  wire        load_i,
    input  wire  [3:0] load_val_i,
    input  wire        en_i,
    output logic       zero_o       // Step from one to zero
);

    logic [3:0] cnt_q;

    // Load wins over count
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= load_val_i;
        end else if (en_i && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign zero_o = en_i && (cnt_q == 4'd1);

endmodule

`default_nettype wire

// File: source/sa_acc_top.sv
`timescale 1ns/1ps
`default_nettype none

module sa_acc_top (
    input  wire                          clk,
    input  wire                          arst_n_i,
    input  wire  sa_acc_pkg::wgt_wr_t    wgt_wr_i,
    input  wire  sa_acc_pkg::pass_cmd_t  cmd_i,
    input  wire                          act_valid_i,
    input  wire  sa_acc_pkg::data_row_t  act_i,
    output logic                         out_valid_o,
    output sa_acc_pkg::data_row_t        out_row_o,
    output logic                         busy_o,
    output logic                         done_o
);
    import sa_acc_pkg::*;

    wgt_wr_t   wgt_wr_g;     // Weight write, blocked while busy
    col_mask_t psum_valid;
    psum_row_t psum_row;
    logic      feed;
    logic      rd_en;
    logic      busy;
    logic      cnt_load;
    logic      cnt_en;
    logic      cnt_zero;
    logic [3:0] cnt_val;

    assign wgt_wr_g = '{we: wgt_wr_i.we & ~busy, row: wgt_wr_i.row, data: wgt_wr_i.data};

    systolic_array u_array (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .wgt_wr_i     (wgt_wr_g),
        .act_valid_i  (feed),
        .act_i        (act_i),
        .psum_valid_o (psum_valid),
        .psum_row_o   (psum_row)
    );

    psum_acc u_acc (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .psum_valid_i (psum_valid),
        .psum_row_i   (psum_row),
        .rd_en_i      (rd_en),
        .out_row_o    (out_row_o)
    );

    tile_ctrl u_ctrl (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cmd_i       (cmd_i),
        .act_valid_i (act_valid_i),
        .cnt_load_o  (cnt_load),
        .cnt_val_o   (cnt_val),
        .cnt_en_o    (cnt_en),
        .cnt_zero_i  (cnt_zero),
        .feed_o      (feed),
        .rd_en_o     (rd_en),
        .busy_o      (busy),
        .done_o      (done_o)
    );

    phase_counter u_cnt (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .load_i     (cnt_load),
        .load_val_i (cnt_val),
        .en_i       (cnt_en),
        .zero_o     (cnt_zero)
    );

    assign out_valid_o = rd_en;     // Drain reads are the output rows
    assign busy_o      = busy;

endmodule

`default_nettype wire

// File: bench/sa_acc_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_acc_config.svh"

module sa_acc_sva (
    input wire                          clk,
    input wire                          arst_n_i,
    input wire  sa_acc_pkg::pass_cmd_t  cmd_i,
    input wire                          feed_i,        // Gated activation strobe
    input wire                          out_valid_i,
    input wire                          busy_i,
    input wire                          done_i
);

    localparam int D = `SA_FIFO_DEPTH;

    logic [3:0] run_len;    // Consecutive output cycles
    logic [3:0] feed_cnt;   // Vectors taken in the running pass
    int         fail_cnt = 0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_len  <= '0;
            feed_cnt <= '0;
        end else begin
            run_len <= out_valid_i ? run_len + 4'd1 : 4'd0;
            if (!busy_i) begin
                feed_cnt <= '0;     // Idle clears the pass
            end else if (feed_i) begin
                feed_cnt <= feed_cnt + 4'd1;
            end
        end
    end

    // Quiet outputs under reset
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n_i |-> !out_valid_i && !done_i && !busy_i)
        else begin $error("outputs active during reset"); fail_cnt++; end

    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_i |=> !done_i)
        else begin $error("done_o held for more than one cycle"); fail_cnt++; end

    a_drain_max: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_valid_i |-> run_len < 4'(D))
        else begin $error("out_valid_o ran past FIFO depth"); fail_cnt++; end

    a_drain_len: assert property (@(posedge clk) disable iff (!arst_n_i)
        $fell(out_valid_i) |-> run_len == 4'(D))
        else begin $error("out_valid_o burst shorter than FIFO depth"); fail_cnt++; end

    a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n_i)
        cmd_i.start && !busy_i |=> busy_i)
        else begin $error("busy_o did not rise after start"); fail_cnt++; end

    a_busy_cause: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(busy_i) |-> $past(cmd_i.start))
        else begin $error("busy_o rose without a start"); fail_cnt++; end

    // A restarted feed phase would take extra vectors
    a_no_restart: assert property (@(posedge clk) disable iff (!arst_n_i)
        feed_i |-> feed_cnt < 4'(D))
        else begin $error("more vectors fed than FIFO depth in one pass"); fail_cnt++; end

endmodule

bind sa_acc_top sa_acc_sva u_sva (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .cmd_i       (cmd_i),
    .feed_i      (feed),
    .out_valid_i (out_valid_o),
    .busy_i      (busy_o),
    .done_i      (done_o)
);

`default_nettype wire

// File: bench/sa_acc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sa_acc_config.svh"

module sa_acc_tb;
    import sa_acc_pkg::*;

    localparam int N               = `SA_PE_SIZE;
    localparam int D               = `SA_FIFO_DEPTH;
    localparam int PASS_CYCLES     = D + `SA_FLUSH_CYCLES + D + 20;
    localparam int NUM_PASSES      = 13;
    localparam int WATCHDOG_CYCLES = 2 * NUM_PASSES * PASS_CYCLES;  // Weight loads, gaps

    logic      clk = 1'b0;
    logic      arst_n_i;
    wgt_wr_t   wgt_wr_i;
    pass_cmd_t cmd_i;
    logic      act_valid_i;
    data_row_t act_i;
    logic      out_valid_o;
    data_row_t out_row_o;
    logic      busy_o;
    logic      done_o;

    data_row_t wgt_m [0:N-1];           // Weights the DUT should hold
    data_row_t acts  [0:D-1];           // Vectors of the next pass
    psum_t     acc_m [0:D-1][0:N-1];    // Column sums per vector slot
    bit        model_full;              // FIFOs hold sums from an earlier pass
    data_row_t exp_q [$];               // Sliced rows still to come out
    data_row_t exp_head;
    int        exp_level;

    logic [31:0] rng_state = 32'd1442;
    string       test_name = "reset";
    int          errors = 0;
    int          row_errors = 0;
    int          extra_rows = 0;
    int          tests_run = 0;
    int          err_start;

    always #4 clk = ~clk;

    sa_acc_top i_sa_acc_top (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .wgt_wr_i    (wgt_wr_i),
        .cmd_i       (cmd_i),
        .act_valid_i (act_valid_i),
        .act_i       (act_i),
        .out_valid_o (out_valid_o),
        .out_row_o   (out_row_o),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic data_row_t rand_row();
        return data_row_t'(next_rand());
    endfunction

    function automatic int fail_total();
        return errors + row_errors + extra_rows + i_sa_acc_top.u_sva.fail_cnt;
    endfunction

    // Head of the expected rows, one pop per presented row
    always @(posedge clk) begin
        if (arst_n_i && out_valid_o && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
        exp_level <= exp_q.size();
    end

    a_row_value: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_valid_o && exp_level > 0 |-> out_row_o == exp_head)
        else begin
            $display("ERROR %s: out_row_o expected %h actual %h", test_name,
                     $sampled(exp_head), $sampled(out_row_o));
            row_errors++;
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_valid_o |-> exp_level > 0)
        else begin
            $display("test %s: output row presented when none was expected", test_name);
            extra_rows++;
        end

    task automatic write_weight_row(input idx_t r, input data_row_t d);
        wgt_wr_i = '{we: 1'b1, row: r, data: d};
        wgt_m[r] = d;       // Only called between passes
        @(negedge clk);
        wgt_wr_i = '0;
    endtask

    task automatic load_weights();
        for (int r = 0; r < N; r++) begin
            write_weight_row(idx_t'(r), rand_row());
        end
    endtask

    task automatic fill_acts(input bit big);
        for (int j = 0; j < D; j++) begin
            acts[j] = rand_row();
            if (big) begin
                acts[j] = acts[j] | data_row_t'(32'h80808080);  // Upper half of the range
            end
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done_o && n < PASS_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!done_o) begin
            $display("test %s: timeout, done_o never pulsed", test_name);
            errors++;
        end
        @(negedge clk);     // Back in idle, last row taken
    endtask

    task automatic run_pass(input bit drain, input bit gaps, input bit poke);
        psum_t     s;
        data_row_t row;
        int        n_gap;
        // Expected sums, zero feedback unless the FIFOs are full
        for (int j = 0; j < D; j++) begin
            for (int c = 0; c < N; c++) begin
                s = '0;
                for (int r = 0; r < N; r++) begin
                    s = s + psum_t'(acts[j][r]) * psum_t'(wgt_m[r][c]);
                end
                acc_m[j][c] = model_full ? acc_m[j][c] + s : s;
            end
        end
        model_full = 1'b1;
        if (drain) begin
            for (int j = 0; j < D; j++) begin
                for (int c = 0; c < N; c++) begin
                    // Eight bits just below the slice index
                    row[c] = data_t'(acc_m[j][c] >> (`SA_SLICING_IDX - `SA_DATA_WIDTH));
                end
                exp_q.push_back(row);
            end
            model_full = 1'b0;      // Drain empties every FIFO
        end
        if (gaps) begin
            act_valid_i = 1'b1;     // Junk while idle
            act_i       = rand_row();
            repeat (2) @(negedge clk);
        end
        cmd_i = '{start: 1'b1, drain: drain};
        @(negedge clk);
        cmd_i = '0;
        for (int j = 0; j < D; j++) begin
            n_gap = gaps ? int'(next_rand() % 32'd4) : 0;
            repeat (n_gap) begin
                act_valid_i = 1'b0;
                act_i       = rand_row();
                @(negedge clk);
            end
            act_valid_i = 1'b1;
            act_i       = acts[j];
            if (poke && j == 2) begin
                cmd_i    = '{start: 1'b1, drain: 1'b1};     // Busy, must be dropped
                wgt_wr_i = '{we: 1'b1, row: idx_t'(1), data: ~wgt_m[1]};
            end
            @(negedge clk);
            cmd_i    = '0;
            wgt_wr_i = '0;
        end
        act_valid_i = gaps;         // Junk during flush and drain
        act_i       = rand_row();
        wait_done();
        act_valid_i = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = fail_total();
    endtask

    task automatic finish_test();
        assert (exp_q.size() == 0)
            else begin
                $display("test %s: %0d expected rows never came out", test_name, exp_q.size());
                errors++;
            end
        $display("test %s: %s", test_name, (fail_total() == err_start) ? "ok" : "failed");
        tests_run++;
    endtask

    initial begin
        arst_n_i    = 1'b1;
        wgt_wr_i    = '0;
        cmd_i       = '0;
        act_valid_i = 1'b0;
        act_i       = '0;
        model_full  = 1'b0;
        #1 arst_n_i = 1'b0;     // Edge for the async reset
        repeat (5) @(negedge clk);
        arst_n_i = 1'b1;

        start_test("single");
        load_weights();
        fill_acts(1'b0);
        run_pass(1'b1, 1'b0, 1'b0);
        finish_test();

        start_test("accumulate");
        for (int p = 0; p < 3; p++) begin
            load_weights();
            fill_acts(1'b0);
            run_pass(p == 2, 1'b0, 1'b0);
        end
        finish_test();

        start_test("preload");
        fill_acts(1'b0);
        run_pass(1'b1, 1'b0, 1'b0);
        finish_test();

        start_test("gapped");
        fill_acts(1'b0);
        run_pass(1'b0, 1'b1, 1'b0);
        fill_acts(1'b0);
        run_pass(1'b1, 1'b1, 1'b0);
        finish_test();

        // Second pass shows whether the busy write leaked in
        start_test("protocol");
        load_weights();
        fill_acts(1'b0);
        run_pass(1'b0, 1'b0, 1'b1);
        fill_acts(1'b0);
        run_pass(1'b1, 1'b0, 1'b0);
        finish_test();

        start_test("random");
        for (int p = 0; p < 4; p++) begin
            load_weights();
            fill_acts(1'b1);
            run_pass((p % 2) == 1, 1'b0, 1'b0);
        end
        finish_test();

        $display("%0d tests run, %0d failed checks", tests_run, fail_total());
        if (fail_total() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sa_acc.f
+incdir+source
source/sa_acc_pkg.sv
source/mac_pe.sv
source/systolic_array.sv
source/acc_fifo.sv
source/psum_acc.sv
source/tile_ctrl.sv
source/phase_counter.sv
source/sa_acc_top.sv
bench/sa_acc_sva.sv
bench/sa_acc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sa_acc testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module sa_acc_tb --Mdir "$OBJ" -f sa_acc.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# Let every assertion failure print instead of stopping at the first one
"./$OBJ/Vsa_acc_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
